// ==== include/dest_config.svh ====
`ifndef DEST_CONFIG_SVH
`define DEST_CONFIG_SVH

// core and packet count ranges
`define DEST_MAX_CORE   10
`define DEST_MAX_NUM    10
`define DEST_CORE_W     4
`define DEST_NUM_W      4

// percent draw for the hotspot decision
`define DEST_PCT_MAX    100
`define DEST_PCT_W      7

// crc draw engine
`define DEST_CRC_W      16
`define DEST_SEED_W     24
`define DEST_CRC_POLY   16'h8005
`define DEST_CRC_INIT   {`DEST_CRC_W{1'b1}}

// hotspot windows, each DEST_HOT_PCT wide, starting every DEST_HOT_SPAN
`define DEST_HOT_PCT    8
`define DEST_HOT_SPAN   20
`define DEST_HOT_COUNT  5   // at most 5

`define DEST_HOT_CORE_1 2
`define DEST_HOT_CORE_2 3
`define DEST_HOT_CORE_3 4
`define DEST_HOT_CORE_4 5
`define DEST_HOT_CORE_5 6

`endif

// ==== hw/dest_pkg.sv ====
`include "dest_config.svh"

package dest_pkg;

    // core index, used for source and destination alike
    typedef logic [`DEST_CORE_W-1:0] core_t;

    // packet count of the source core
    typedef logic [`DEST_NUM_W-1:0] num_t;

    // percent draw, folded into 0..DEST_PCT_MAX
    typedef logic [`DEST_PCT_W-1:0] pct_t;

endpackage

// ==== hw/rand_draw.sv ====
`include "dest_config.svh"

module rand_draw #(
    parameter int  MAX_VALUE = `DEST_MAX_CORE,
    parameter type value_t   = dest_pkg::core_t
) (
    input  logic             clk,
    input  logic             rst,
    input  dest_pkg::core_t  seed_core,
    input  dest_pkg::num_t   seed_num,
    input  logic             advance,
    output value_t           value
);

    localparam int UNIT_W = $bits(dest_pkg::core_t) + $bits(dest_pkg::num_t);
    localparam int REPS   = `DEST_SEED_W / UNIT_W;
    localparam int VAL_W  = $bits(value_t);

    logic [`DEST_SEED_W-1:0] seed;
    logic [`DEST_CRC_W-1:0]  crc_q;
    logic [`DEST_CRC_W-1:0]  crc_next;
    logic [VAL_W-1:0]        field;

    // one crc-16 pass over the seed, data bit 0 first
    function automatic logic [`DEST_CRC_W-1:0] crc_step(
        input logic [`DEST_CRC_W-1:0]  state,
        input logic [`DEST_SEED_W-1:0] data
    );
        logic [`DEST_CRC_W-1:0] s;
        logic                   fb;
        s = state;
        for (int i = 0; i < `DEST_SEED_W; i++) begin
            fb = s[`DEST_CRC_W-1] ^ data[i];
            s  = {s[`DEST_CRC_W-2:0], 1'b0};
            if (fb) begin
                s = s ^ `DEST_CRC_POLY;
            end
        end
        return s;
    endfunction

    // {core, num} repeated, first copy lands in the low byte
    assign seed     = {REPS{seed_core, seed_num}};
    assign crc_next = crc_step(crc_q, seed);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_q <= `DEST_CRC_INIT;
        end else if (advance) begin
            crc_q <= crc_next;
        end
    end

    assign field = crc_q[VAL_W-1:0];

    // fold the overflow part back into range
    always_comb begin
        if (field > VAL_W'(MAX_VALUE)) begin
            value = value_t'(field - VAL_W'(MAX_VALUE));
        end else begin
            value = value_t'(field);
        end
    end

    // folding only works while the field is below twice the max
    a_value_range: assert property (
        @(posedge clk) disable iff (rst)
        value <= value_t'(MAX_VALUE)
    ) else $error("rand_draw value %0d above %0d", value, MAX_VALUE);

endmodule

// ==== hw/uniform_dest.sv ====
`include "dest_config.svh"

module uniform_dest (
    input  logic            clk,
    input  logic            rst,
    input  logic            rnd_en,
    input  dest_pkg::core_t core,
    input  dest_pkg::num_t  num,
    output dest_pkg::core_t dest
);

    dest_pkg::core_t r1;
    dest_pkg::core_t r2;
    dest_pkg::core_t r3;
    dest_pkg::core_t core2;
    dest_pkg::core_t core3;
    dest_pkg::num_t  num2;
    dest_pkg::num_t  num3;

    // seeds for draws 2 and 3, wrap on overflow
    assign core2 = dest_pkg::core_t'(core + core);
    assign num2  = dest_pkg::num_t'(num + num);
    assign core3 = dest_pkg::core_t'(core + r1);
    assign num3  = dest_pkg::num_t'(num + dest_pkg::num_t'(r2));

    rand_draw #(
        .MAX_VALUE (`DEST_MAX_CORE),
        .value_t   (dest_pkg::core_t)
    ) draw1 (
        .clk       (clk),
        .rst       (rst),
        .seed_core (core),
        .seed_num  (num),
        .advance   (rnd_en),
        .value     (r1)
    );

    rand_draw #(
        .MAX_VALUE (`DEST_MAX_CORE),
        .value_t   (dest_pkg::core_t)
    ) draw2 (
        .clk       (clk),
        .rst       (rst),
        .seed_core (core2),
        .seed_num  (num2),
        .advance   (rnd_en),
        .value     (r2)
    );

    rand_draw #(
        .MAX_VALUE (`DEST_MAX_CORE),
        .value_t   (dest_pkg::core_t)
    ) draw3 (
        .clk       (clk),
        .rst       (rst),
        .seed_core (core3),
        .seed_num  (num3),
        .advance   (rnd_en),
        .value     (r3)
    );

    always_comb begin
        if (r1 != core) begin
            dest = r1;
        end else if (r2 != core) begin
            dest = r2;
        end else if (r3 != core) begin
            dest = r3;
        end else if (core == dest_pkg::core_t'(`DEST_MAX_CORE)) begin
            dest = '0;              // wrap around at the top core
        end else begin
            dest = r1 + 1'b1;       // r1 equals core here
        end
    end

    a_no_self: assert property (
        @(posedge clk) disable iff (rst)
        dest != core
    ) else $error("uniform dest %0d equals source core", dest);

    a_dest_range: assert property (
        @(posedge clk) disable iff (rst)
        (core <= dest_pkg::core_t'(`DEST_MAX_CORE)) |-> (dest <= dest_pkg::core_t'(`DEST_MAX_CORE))
    ) else $error("uniform dest %0d out of range", dest);

endmodule

// ==== hw/hotspot_select.sv ====
`include "dest_config.svh"

module hotspot_select (
    input  logic            clk,
    input  logic            rst,
    input  logic            rnd_en,
    input  dest_pkg::core_t core,
    input  dest_pkg::num_t  num,
    input  dest_pkg::core_t uniform_dest,
    output dest_pkg::core_t dest
);

    localparam dest_pkg::core_t HOT_CORE [5] = '{
        dest_pkg::core_t'(`DEST_HOT_CORE_1),
        dest_pkg::core_t'(`DEST_HOT_CORE_2),
        dest_pkg::core_t'(`DEST_HOT_CORE_3),
        dest_pkg::core_t'(`DEST_HOT_CORE_4),
        dest_pkg::core_t'(`DEST_HOT_CORE_5)
    };

    dest_pkg::pct_t pct;

    // percent draw in 0..DEST_PCT_MAX
    rand_draw #(
        .MAX_VALUE (`DEST_PCT_MAX),
        .value_t   (dest_pkg::pct_t)
    ) pct_draw (
        .clk       (clk),
        .rst       (rst),
        .seed_core (core),
        .seed_num  (num),
        .advance   (rnd_en),
        .value     (pct)
    );

    // first window holding the draw wins, unless its hotspot is the source
    always_comb begin
        logic hit;
        int   lo;
        hit  = 1'b0;
        dest = uniform_dest;
        for (int k = 0; k < `DEST_HOT_COUNT; k++) begin
            lo = k * `DEST_HOT_SPAN;
            if (!hit && int'(pct) >= lo && int'(pct) < lo + `DEST_HOT_PCT
                    && HOT_CORE[k] != core) begin
                hit  = 1'b1;
                dest = HOT_CORE[k];
            end
        end
    end

endmodule

// ==== hw/traffic_dest_gen.sv ====
`include "dest_config.svh"

module traffic_dest_gen (
    input  logic            clk,
    input  logic            rst,
    input  logic            rnd_en,
    input  dest_pkg::core_t core,
    input  dest_pkg::num_t  num,
    output dest_pkg::core_t dest
);

    dest_pkg::core_t uni_dest;  // fallback when no hotspot fires

    uniform_dest u_uniform (
        .clk    (clk),
        .rst    (rst),
        .rnd_en (rnd_en),
        .core   (core),
        .num    (num),
        .dest   (uni_dest)
    );

    hotspot_select u_hotspot (
        .clk          (clk),
        .rst          (rst),
        .rnd_en       (rnd_en),
        .core         (core),
        .num          (num),
        .uniform_dest (uni_dest),
        .dest         (dest)
    );

    // out of range sources would break the no-self guarantee downstream
    a_input_range: assert property (
        @(posedge clk) disable iff (rst)
        rnd_en |-> (core <= dest_pkg::core_t'(`DEST_MAX_CORE)
                    && num <= dest_pkg::num_t'(`DEST_MAX_NUM))
    ) else $error("core %0d or num %0d out of range", core, num);

endmodule

// ==== sim/dest_checker.sv ====
`include "dest_config.svh"

module dest_checker (
    input  logic            clk,
    input  logic            rst,
    input  logic            rnd_en,
    input  dest_pkg::core_t core,
    input  dest_pkg::num_t  num,
    input  dest_pkg::core_t dest,
    output int              errors,
    output int              checks
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HOT_LIST [5] = '{
        `DEST_HOT_CORE_1,
        `DEST_HOT_CORE_2,
        `DEST_HOT_CORE_3,
        `DEST_HOT_CORE_4,
        `DEST_HOT_CORE_5
    };

    // model crc states: uniform draws 1..3 and the percent draw
    logic [`DEST_CRC_W-1:0] st_u1;
    logic [`DEST_CRC_W-1:0] st_u2;
    logic [`DEST_CRC_W-1:0] st_u3;
    logic [`DEST_CRC_W-1:0] st_pct;
    logic                   last_adv;   // rnd_en seen at the last rising edge
    logic                   have_prev;
    dest_pkg::core_t        prev_core;
    dest_pkg::core_t        prev_dest;
    dest_pkg::num_t         prev_num;
    int                     err_count = 0;
    int                     check_count = 0;

    assign errors = err_count;
    assign checks = check_count;

    // crc-16, poly 0x8005, seed bits taken lsb first
    function automatic logic [`DEST_CRC_W-1:0] crc_model(
        input logic [`DEST_CRC_W-1:0] st,
        input dest_pkg::core_t        c,
        input dest_pkg::num_t         n
    );
        logic [`DEST_SEED_W-1:0] data;
        logic [`DEST_CRC_W-1:0]  r;
        logic                    fb;
        data = {c, n, c, n, c, n};
        r = st;
        for (int b = 0; b < `DEST_SEED_W; b++) begin
            fb = r[`DEST_CRC_W-1] ^ data[b];
            r = r << 1;
            if (fb) begin
                r = r ^ `DEST_CRC_POLY;
            end
        end
        return r;
    endfunction

    function automatic int folded(input int field, input int max_v);
        return (field > max_v) ? field - max_v : field;
    endfunction

    function automatic int core_draw(input logic [`DEST_CRC_W-1:0] st);
        return folded(int'(st[`DEST_CORE_W-1:0]), `DEST_MAX_CORE);
    endfunction

    // expected destination for the given model states and source
    function automatic int expected_dest(
        input logic [`DEST_CRC_W-1:0] s1,
        input logic [`DEST_CRC_W-1:0] s2,
        input logic [`DEST_CRC_W-1:0] s3,
        input logic [`DEST_CRC_W-1:0] sp,
        input int                     src
    );
        int r1;
        int r2;
        int r3;
        int pct;
        int uni;
        int lo;
        r1  = core_draw(s1);
        r2  = core_draw(s2);
        r3  = core_draw(s3);
        pct = folded(int'(sp[`DEST_PCT_W-1:0]), `DEST_PCT_MAX);
        if (r1 != src) begin
            uni = r1;
        end else if (r2 != src) begin
            uni = r2;
        end else if (r3 != src) begin
            uni = r3;
        end else if (src == `DEST_MAX_CORE) begin
            uni = 0;
        end else begin
            uni = r1 + 1;
        end
        for (int k = 0; k < `DEST_HOT_COUNT; k++) begin
            lo = k * `DEST_HOT_SPAN;
            // a hotspot equal to the source is skipped
            if (pct >= lo && pct < lo + `DEST_HOT_PCT && HOT_LIST[k] != src) begin
                return HOT_LIST[k];
            end
        end
        return uni;
    endfunction

    // model advance, draw 3 seeds use the draws before the edge
    always @(posedge clk or posedge rst) begin
        int r1;
        int r2;
        if (rst) begin
            st_u1    <= `DEST_CRC_INIT;
            st_u2    <= `DEST_CRC_INIT;
            st_u3    <= `DEST_CRC_INIT;
            st_pct   <= `DEST_CRC_INIT;
            last_adv <= 1'b0;
        end else begin
            r1 = core_draw(st_u1);
            r2 = core_draw(st_u2);
            last_adv <= rnd_en;
            if (rnd_en) begin
                st_u1  <= crc_model(st_u1, core, num);
                st_u2  <= crc_model(st_u2, core + core, num + num);
                st_u3  <= crc_model(st_u3, core + dest_pkg::core_t'(r1),
                                    num + dest_pkg::num_t'(r2));
                st_pct <= crc_model(st_pct, core, num);
            end
        end
    end

    // compare mid cycle, dest settled from state and inputs
    always @(negedge clk) begin
        int exp_d;
        if (rst) begin
            have_prev = 1'b0;
        end else begin
            exp_d = expected_dest(st_u1, st_u2, st_u3, st_pct, int'(core));
            check_count = check_count + 1;
            if (int'(dest) != exp_d) begin
                $display("Error at %0t: dest expected %0d actual %0d", $time, exp_d, dest);
                err_count = err_count + 1;
            end
            if (dest == core) begin
                $display("Error at %0t: dest %0d equals source core %0d", $time, dest, core);
                err_count = err_count + 1;
            end
            if (dest > dest_pkg::core_t'(`DEST_MAX_CORE)) begin
                $display("Error at %0t: dest %0d above highest core %0d",
                         $time, dest, `DEST_MAX_CORE);
                err_count = err_count + 1;
            end
            if (have_prev && !last_adv && core == prev_core && num == prev_num
                    && dest != prev_dest) begin
                $display("Error at %0t: dest changed from %0d to %0d with rnd_en low",
                         $time, prev_dest, dest);
                err_count = err_count + 1;
            end
            prev_core = core;
            prev_num  = num;
            prev_dest = dest;
            have_prev = 1'b1;
        end
    end

endmodule

// ==== sim/tb_top.sv ====
`include "dest_config.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLE_LIMIT   = 20;     // cycles allowed per comparison
    localparam int RANDOM_CYCLES = 2000;

    logic            clk;
    logic            rst;
    logic            rnd_en;
    dest_pkg::core_t core;
    dest_pkg::num_t  num;
    dest_pkg::core_t dest;
    int              errors;
    int              checks;
    bit              timed_out;

    traffic_dest_gen dut0 (
        .clk    (clk),
        .rst    (rst),
        .rnd_en (rnd_en),
        .core   (core),
        .num    (num),
        .dest   (dest)
    );

    dest_checker chk0 (
        .clk    (clk),
        .rst    (rst),
        .rnd_en (rnd_en),
        .core   (core),
        .num    (num),
        .dest   (dest),
        .errors (errors),
        .checks (checks)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // wait until the checker has compared the current inputs
    task automatic wait_compared();
        int start;
        int t;
        start = checks;
        t = 0;
        while (checks == start && t < CYCLE_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (checks == start) begin
            $display("Timeout: checker made no comparison within %0d cycles", CYCLE_LIMIT);
            timed_out = 1'b1;
        end else begin
            #1;     // drive just after the edge
        end
    endtask

    task automatic apply(input logic en, input int c, input int n);
        if (timed_out) begin
            return;
        end
        rnd_en = en;
        core   = dest_pkg::core_t'(c);
        num    = dest_pkg::num_t'(n);
        wait_compared();
    endtask

    initial begin
        int   nc;
        int   nn;
        logic en;
        void'($urandom(32'hb2ef_96ee));
        rst       = 1'b1;
        rnd_en    = 1'b0;
        core      = '0;
        num       = '0;
        timed_out = 1'b0;
        nc        = 0;
        nn        = 0;
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
        end
        #1 rst = 1'b0;

        // one draw per source core including the hotspot cores
        for (int c = 0; c <= `DEST_MAX_CORE; c++) begin
            apply(1'b1, c, $urandom_range(`DEST_MAX_NUM, 0));
        end

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            en = ($urandom_range(3, 0) != 0);
            if ($urandom_range(1, 0) != 0) begin    // else hold inputs
                nc = $urandom_range(`DEST_MAX_CORE, 0);
                nn = $urandom_range(`DEST_MAX_NUM, 0);
            end
            apply(en, nc, nn);
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out && checks > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
hw/dest_pkg.sv
hw/rand_draw.sv
hw/uniform_dest.sv
hw/hotspot_select.sv
hw/traffic_dest_gen.sv
sim/dest_checker.sv
sim/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the destination generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_top -f flist.f -o tb_top_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_top_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
